// File: design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // address split of a 32-bit byte address
    localparam int TAG_MSB    = 31;             // tag is the top 18 bits
    localparam int TAG_LSB    = 14;
    localparam int INDEX_MSB  = 13;             // 10-bit line index
    localparam int INDEX_LSB  = 4;
    localparam int OFFSET_MSB = 3;              // word within the line
    localparam int OFFSET_LSB = 2;              // below this the byte lane, always zero

    // geometry of the array
    localparam int NUM_LINES      = 1024;       // one line per index value
    localparam int WORDS_PER_LINE = 4;          // 16-byte lines

    // widths that carry a meaning
    typedef logic [31:0] addr_t;                // byte address, cpu and memory side
    typedef logic [31:0] word_t;                // one data word
    typedef logic [TAG_MSB-TAG_LSB:0] tag_t;    // 18-bit tag
    typedef logic [INDEX_MSB-INDEX_LSB:0] index_t;      // line index
    typedef logic [OFFSET_MSB-OFFSET_LSB:0] offset_t;   // word offset, also beat number

    // controller states
    typedef enum logic [1:0] {
        st_idle,                                // waiting for a cpu request
        st_compare,                             // tag check, hit or miss decision
        st_write_back,                          // dirty victim out, four beats
        st_allocate                             // refill from memory, four beats
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/cache_array_if.sv
`default_nettype none

interface cache_array_if import cache_pkg::*; ();

    // request side, driven by the controller
    index_t  index;                             // line being looked at
    offset_t word_sel;                          // word lane for read and write
    logic    tag_we;                            // tag write, also sets valid
    tag_t    wr_tag;                            // new tag
    logic    wr_dirty;                          // new dirty bit
    logic    data_we;                           // single word write
    word_t   data_wdata;                        // word to store

    // read-back, combinational from index and word_sel
    tag_t    rd_tag;                            // stored tag
    logic    rd_valid;                          // line holds data
    logic    rd_dirty;                          // line differs from memory
    word_t   data_rdata;                        // stored word

    modport ctrl (
        output index, word_sel, tag_we, wr_tag, wr_dirty, data_we, data_wdata,
        input  rd_tag, rd_valid, rd_dirty, data_rdata
    );

    modport tag_ram (
        input  index, tag_we, wr_tag, wr_dirty,
        output rd_tag, rd_valid, rd_dirty
    );

    modport data_ram (
        input  index, word_sel, data_we, data_wdata,
        output data_rdata
    );

endinterface

`default_nettype wire

// File: design/cache_tag_ram.sv
`default_nettype none

module cache_tag_ram import cache_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    cache_array_if.tag_ram arr
);

    tag_t                 tag_mem   [NUM_LINES];  // stored tags
    logic                 dirty_mem [NUM_LINES];  // one dirty bit per line
    logic [NUM_LINES-1:0] valid_q;                // cleared on reset

    // one valid flop per line
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;                        // cold cache
        end else if (arr.tag_we) begin
            valid_q[arr.index] <= 1'b1;           // any tag write claims the line
        end
    end

    // tag and dirty storage written on the edge
    always_ff @(posedge clk) begin
        if (arr.tag_we) begin
            tag_mem[arr.index]   <= arr.wr_tag;   // new or unchanged tag
            dirty_mem[arr.index] <= arr.wr_dirty; // set on write and cleared on read alloc
        end
    end

    // asynchronous read of the addressed entry
    assign arr.rd_tag   = tag_mem[arr.index];
    assign arr.rd_valid = valid_q[arr.index];
    assign arr.rd_dirty = dirty_mem[arr.index];

endmodule

`default_nettype wire

// File: design/cache_data_ram.sv
`default_nettype none

module cache_data_ram import cache_pkg::*; (
    input  wire logic clk,
    cache_array_if.data_ram arr
);

    word_t lane_rdata [WORDS_PER_LINE];           // read word of each lane

    // One memory per word lane. Only the lane at word_sel is written,
    // so CPU stores, refill beats and write-back reads share this port.
    for (genvar l = 0; l < WORDS_PER_LINE; l++) begin : g_lane
        word_t lane_mem [NUM_LINES];              // words at offset l of every line

        always_ff @(posedge clk) begin
            if (arr.data_we && (arr.word_sel == offset_t'(l))) begin
                lane_mem[arr.index] <= arr.data_wdata;  // one word per edge
            end
        end

        assign lane_rdata[l] = lane_mem[arr.index];     // combinational read
    end

    // pick the addressed lane
    assign arr.data_rdata = lane_rdata[arr.word_sel];

endmodule

`default_nettype wire

// File: design/line_beat_counter.sv
`default_nettype none

module line_beat_counter import cache_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    beat_clr,             // start of a line transfer
    input  wire logic    beat_inc,             // one memory beat accepted
    output offset_t      beat,                 // current word of the transfer
    output logic         last_beat             // fourth word in flight
);

    offset_t beat_q;                           // beat count

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= '0;
        end else if (beat_clr) begin
            beat_q <= '0;                      // clear wins over increment
        end else if (beat_inc) begin
            beat_q <= beat_q + offset_t'(1);   // wraps 3 -> 0
        end
    end

    assign beat      = beat_q;
    assign last_beat = (beat_q == offset_t'(WORDS_PER_LINE - 1));  // decode of beat 3

endmodule

`default_nettype wire

// File: design/cache_ctrl_fsm.sv
`default_nettype none

module cache_ctrl_fsm import cache_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    // cpu port
    input  wire logic    cpu_valid,
    input  wire logic    cpu_rw,            // 1 = write
    input  wire addr_t   cpu_addr,
    input  wire word_t   cpu_wdata,
    output logic         cpu_ready,         // one-cycle done pulse
    output word_t        cpu_rdata,
    // memory port
    output logic         mem_valid,
    output logic         mem_rw,            // 1 = write beat
    output addr_t        mem_addr,          // word byte address
    output word_t        mem_wdata,
    input  wire logic    mem_ready,
    input  wire word_t   mem_rdata,
    // beat counter
    input  wire offset_t beat,
    input  wire logic    last_beat,
    output logic         beat_clr,
    output logic         beat_inc,
    // tag and data arrays
    cache_array_if.ctrl  arr
);

    ctrl_state_t state_q;                   // current state
    ctrl_state_t state_d;                   // next state
    logic        cpu_ready_q;               // registered done pulse
    word_t       cpu_rdata_q;               // word captured on a hit
    tag_t        victim_tag_q;              // old tag for write-back addresses

    tag_t        cpu_tag;
    index_t      cpu_index;
    offset_t     cpu_offset;
    logic        hit;                       // tag match on a valid line
    logic        victim_dirty;              // miss must write back first

    // address split of the held request
    assign cpu_tag    = cpu_addr[TAG_MSB:TAG_LSB];
    assign cpu_index  = cpu_addr[INDEX_MSB:INDEX_LSB];
    assign cpu_offset = cpu_addr[OFFSET_MSB:OFFSET_LSB];

    assign hit          = arr.rd_valid && (arr.rd_tag == cpu_tag);
    assign victim_dirty = arr.rd_valid && arr.rd_dirty;

    always_comb begin
        // by default look at the cpu's line and word and write nothing
        state_d        = state_q;
        arr.index      = cpu_index;
        arr.word_sel   = cpu_offset;
        arr.tag_we     = 1'b0;
        arr.wr_tag     = cpu_tag;
        arr.wr_dirty   = cpu_rw;
        arr.data_we    = 1'b0;
        arr.data_wdata = cpu_wdata;         // cpu store data unless refilling
        mem_valid      = 1'b0;
        mem_rw         = 1'b0;
        mem_addr       = {cpu_tag, cpu_index, beat, {OFFSET_LSB{1'b0}}};
        mem_wdata      = arr.data_rdata;    // victim word during write-back
        beat_clr       = 1'b0;
        beat_inc       = 1'b0;

        case (state_q)
            st_idle: begin
                // ready still high means the request just finished
                if (cpu_valid && !cpu_ready_q) begin
                    state_d = st_compare;
                end
            end

            st_compare: begin
                if (hit) begin
                    if (cpu_rw) begin
                        arr.tag_we   = 1'b1;    // rewrite own tag with dirty set
                        arr.data_we  = 1'b1;    // merge the cpu word
                    end
                    state_d = st_idle;
                end else begin
                    arr.tag_we = 1'b1;          // claim the line for the new tag
                    beat_clr   = 1'b1;          // transfer starts at offset 0
                    if (victim_dirty) begin
                        state_d = st_write_back;
                    end else begin
                        state_d = st_allocate;  // empty or clean victim needs no write-back
                    end
                end
            end

            st_write_back: begin
                arr.word_sel = beat;            // read victim word by word
                mem_valid    = 1'b1;
                mem_rw       = 1'b1;
                mem_addr     = {victim_tag_q, cpu_index, beat, {OFFSET_LSB{1'b0}}};
                if (mem_ready) begin
                    beat_inc = 1'b1;
                    if (last_beat) begin
                        beat_clr = 1'b1;        // refill also starts at 0
                        state_d  = st_allocate;
                    end
                end
            end

            st_allocate: begin
                arr.word_sel = beat;            // lane of the incoming word
                mem_valid    = 1'b1;
                if (mem_ready) begin
                    beat_inc       = 1'b1;
                    arr.data_we    = 1'b1;
                    arr.data_wdata = mem_rdata; // refill beat into the array
                    if (last_beat) begin
                        state_d = st_compare;   // re-check now hits
                    end
                end
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= st_idle;
            cpu_ready_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cpu_ready_q <= (state_q == st_compare) && hit;   // done one cycle later
        end
    end

    // payload captures
    always_ff @(posedge clk) begin
        if ((state_q == st_compare) && hit) begin
            cpu_rdata_q <= arr.data_rdata;      // addressed word for the cpu
        end
        if ((state_q == st_compare) && !hit) begin
            victim_tag_q <= arr.rd_tag;         // before the tag is overwritten
        end
    end

    assign cpu_ready = cpu_ready_q;
    assign cpu_rdata = cpu_rdata_q;

endmodule

`default_nettype wire

// File: design/dm_cache_top.sv
`default_nettype none

module dm_cache_top import cache_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    // cpu side
    input  wire logic  cpu_valid,
    input  wire logic  cpu_rw,               // 1 = write
    input  wire addr_t cpu_addr,
    input  wire word_t cpu_wdata,
    output logic       cpu_ready,
    output word_t      cpu_rdata,
    // main memory side
    output logic       mem_valid,
    output logic       mem_rw,               // 1 = write beat
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    input  wire logic  mem_ready,
    input  wire word_t mem_rdata
);

    offset_t beat;                           // current transfer word
    logic    last_beat;                      // fourth beat
    logic    beat_clr;
    logic    beat_inc;

    cache_array_if arr ();                   // controller to tag and data arrays

    cache_ctrl_fsm u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_rw    (cpu_rw),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .mem_valid (mem_valid),
        .mem_rw    (mem_rw),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .beat      (beat),
        .last_beat (last_beat),
        .beat_clr  (beat_clr),
        .beat_inc  (beat_inc),
        .arr       (arr.ctrl)
    );

    cache_tag_ram u_tag (
        .clk (clk),
        .rst (rst),
        .arr (arr.tag_ram)
    );

    cache_data_ram u_data (
        .clk (clk),
        .arr (arr.data_ram)
    );

    line_beat_counter u_beat (
        .clk       (clk),
        .rst       (rst),
        .beat_clr  (beat_clr),
        .beat_inc  (beat_inc),
        .beat      (beat),
        .last_beat (last_beat)
    );

endmodule

`default_nettype wire

// File: verification/mem_model.sv
`default_nettype none

module mem_model import cache_pkg::*; (
    input  wire logic  clk,
    input  wire logic  mem_valid,
    input  wire logic  mem_rw,               // 1 = write beat
    input  wire addr_t mem_addr,
    input  wire word_t mem_wdata,
    output logic       mem_ready,
    output word_t      mem_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t store [addr_t];                   // written words only, rest is the fill pattern
    logic  log_rw   [$];                     // every accepted beat, oldest first
    addr_t log_addr [$];
    word_t log_data [$];
    int    wait_left;                        // valid cycles before the next ready

    // contents before any write, every address bit feeds in
    function automatic word_t fill_word(addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    // outputs change 1 ns after the edge, request is stable by then
    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_valid && wait_left == 0) begin
                mem_ready = 1'b1;            // beat taken at the next edge
                if (mem_rw) begin
                    store[mem_addr] = mem_wdata;
                end else begin
                    mem_rdata = store.exists(mem_addr) ? store[mem_addr] : fill_word(mem_addr);
                end
                log_rw.push_back(mem_rw);
                log_addr.push_back(mem_addr);
                log_data.push_back(mem_rw ? mem_wdata : mem_rdata);
                wait_left = $urandom % 4;    // 0 to 3 cycles of back-pressure
            end else begin
                mem_ready = 1'b0;
                if (mem_valid && wait_left > 0) wait_left--;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/dm_cache_tb.sv
`default_nettype none

module dm_cache_tb import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic  clk;
    logic  rst;
    logic  cpu_valid;
    logic  cpu_rw;                           // 1 = write
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  cpu_ready;
    word_t cpu_rdata;
    logic  mem_valid;
    logic  mem_rw;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_ready;
    word_t mem_rdata;

    word_t shadow [addr_t];                  // cpu view of written words
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    n0;                               // memory log size before the last access
    int    cycles;                           // edges from request to cpu_ready
    logic  saw_mem;                          // mem_valid seen in the last access
    word_t rdata;

    dm_cache_top dut (.*);
    mem_model    u_mem (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;                    // 4 ns period

    // same fill rule the memory starts with
    function automatic word_t fill_word(addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t expect_word(addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic addr_t line_addr(tag_t t, index_t i, offset_t o);
        return {t, i, o, 2'b00};
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // one cpu request, held until cpu_ready, then one idle cycle
    task automatic access(input logic rw, input addr_t addr, input word_t wdata);
        n0        = u_mem.log_addr.size();
        cpu_valid = 1'b1;
        cpu_rw    = rw;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cycles    = 0;
        saw_mem   = 1'b0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            saw_mem |= mem_valid;
        end while (!cpu_ready && cycles < 200);
        if (!cpu_ready) begin
            $display("timeout: no cpu_ready within 200 cycles for address %h", addr);
            $display("tests failed");
            $finish;
        end else begin
            rdata     = cpu_rdata;
            cpu_valid = 1'b0;
            for (int n = n0; n < u_mem.log_addr.size(); n++) begin
                if (u_mem.log_rw[n])         // victim words must match the cpu view
                    assert (u_mem.log_data[n] == expect_word(u_mem.log_addr[n]))
                    else report_error($sformatf("write-back of %h carries %h",
                        u_mem.log_addr[n], u_mem.log_data[n]));
            end
            if (rw) begin
                shadow[addr] = wdata;
            end else begin
                assert (rdata == expect_word(addr))
                else report_error($sformatf("read %h got %h, expected %h",
                    addr, rdata, expect_word(addr)));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_hit();
        assert (cycles == 2 && !saw_mem)
        else report_error($sformatf("hit took %0d cycles, mem_valid seen %b", cycles, saw_mem));
    endtask

    task automatic check_count(input int exp);
        assert (u_mem.log_addr.size() - n0 == exp)
        else report_error($sformatf("%0d memory beats, expected %0d",
            u_mem.log_addr.size() - n0, exp));
    endtask

    // four beats over one line, offsets in order
    task automatic check_line(input int first, input logic rw, input addr_t base);
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            assert (u_mem.log_rw[first + k] == rw && u_mem.log_addr[first + k] == base + 4 * k)
            else report_error($sformatf("beat %0d is not a %s of %h", k,
                rw ? "write" : "read", base + 4 * k));
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        addr_t a;
        addr_t b;
        addr_t c;
        word_t w;
        int    e0;
        void'($urandom(32'h501f6f62));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        cpu_valid    = 1'b0;
        cpu_rw       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        e0 = errors;
        repeat (20) begin                    // idle cache stays quiet
            @(posedge clk);
            #1;
            assert (!cpu_ready && !mem_valid) else report_error("cpu_ready or mem_valid while idle");
        end
        end_test("reset", e0);

        e0 = errors;
        a  = line_addr(18'h00012, 10'h005, 2'd0);
        access(1'b0, a + 8, '0);
        check_count(4);                      // refill only, cold line
        check_line(n0, 1'b0, a);
        end_test("cold_read_miss", e0);

        e0 = errors;
        for (int o = 0; o < WORDS_PER_LINE; o++) begin
            access(1'b0, a + 4 * o, '0);
            check_hit();
        end
        end_test("read_hit", e0);

        e0 = errors;
        w  = $urandom;
        access(1'b1, a + 4, w);
        check_hit();
        access(1'b0, a + 4, '0);             // line still resident, no write-back
        check_hit();
        end_test("write_hit", e0);

        e0 = errors;
        b  = line_addr(18'h00345, 10'h005, 2'd0);
        access(1'b0, b + 12, '0);
        check_count(8);
        check_line(n0, 1'b1, a);             // old tag goes out first
        check_line(n0 + 4, 1'b0, b);
        assert (u_mem.log_data[n0 + 1] == w) else report_error("write-back lost the stored word");
        end_test("dirty_evict", e0);

        e0 = errors;
        c  = line_addr(18'h02a7c, 10'h0a0, 2'd0);
        access(1'b1, c + 12, $urandom);      // empty line
        check_count(4);
        check_line(n0, 1'b0, c);
        access(1'b1, a, $urandom);           // clean victim b, no write beats
        check_count(4);
        check_line(n0, 1'b0, a);
        access(1'b0, c + 12, '0);
        check_hit();
        access(1'b0, a, '0);
        check_hit();
        end_test("write_miss", e0);

        e0 = errors;
        for (int i = 0; i < 200; i++) begin  // few tags over three indices, lots of conflicts
            a = line_addr(tag_t'($urandom % 4), index_t'(10'h040 + $urandom % 3),
                offset_t'($urandom));
            access(1'($urandom % 2), a, $urandom);
        end
        end_test("random_mix", e0);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dm_cache_top.f
design/cache_pkg.sv
design/cache_array_if.sv
design/cache_tag_ram.sv
design/cache_data_ram.sv
design/line_beat_counter.sv
design/cache_ctrl_fsm.sv
design/dm_cache_top.sv
verification/mem_model.sv
verification/dm_cache_tb.sv

// File: Bender.yml
package:
  name: dm_cache

sources:
  - design/cache_pkg.sv
  - design/cache_array_if.sv
  - design/cache_tag_ram.sv
  - design/cache_data_ram.sv
  - design/line_beat_counter.sv
  - design/cache_ctrl_fsm.sv
  - design/dm_cache_top.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/dm_cache_tb.sv
